// File: fdc_glue.f
verilog/fdc_pkg.sv
verilog/precomp_if.sv
verilog/fdc_sync.sv
verilog/vg_clock_gen.sv
verilog/sys_port.sv
verilog/wr_precomp.sv
verilog/wr_pulse.sv
verilog/rd_dpll.sv
verilog/fdc_glue.sv
tests/tb_clock.sv
tests/fdc_glue_tb.sv

// File: Bender.yml
package:
  name: fdc_glue

sources:
  - files:
      - verilog/fdc_pkg.sv
      - verilog/precomp_if.sv
      - verilog/fdc_sync.sv
      - verilog/vg_clock_gen.sv
      - verilog/sys_port.sv
      - verilog/wr_precomp.sv
      - verilog/wr_pulse.sv
      - verilog/rd_dpll.sv
      - verilog/fdc_glue.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/fdc_glue_tb.sv

// File: tests/fdc_glue_tb.sv
`timescale 1ns/1ns

module fdc_glue_tb;

	typedef enum int
	{
		k_write,
		k_port,
		k_rdat,
		k_clk
	} row_kind_e;

	localparam int num_rows    = 11;
	localparam int cycle_limit = 300 * num_rows + 200;

	logic       fclk;
	logic       rst_n;
	logic       wr_ff;
	logic [7:0] din;
	logic       step;
	logic       vg_drq;
	logic       vg_irq;
	logic       vg_wd;
	logic       vg_sl;
	logic       vg_sr;
	logic       vg_tr43;
	logic       rdat_n;
	logic       vg_clk;
	logic       vg_res_n;
	logic       vg_hrdy;
	logic       vg_side;
	logic [1:0] drive_sel;
	logic       intrq;
	logic       drq;
	logic       vg_wrd;
	logic       vg_rclk;
	logic       vg_rawr;

	row_kind_e  row_kind [num_rows];
	logic [2:0] row_stim [num_rows]; // {sl, sr, tr43} on write rows
	int         row_exp  [num_rows];
	string      row_name [num_rows];

	logic [31:0] lfsr;
	logic [31:0] gap;
	int          cycle_cnt;
	int          r;

	tb_clock clk_gen_i
	(
		.fclk  (fclk),
		.rst_n (rst_n)
	);

	fdc_glue dut_i
	(
		.fclk      (fclk),
		.rst_n     (rst_n),
		.wr_ff     (wr_ff),
		.din       (din),
		.step      (step),
		.vg_drq    (vg_drq),
		.vg_irq    (vg_irq),
		.vg_wd     (vg_wd),
		.vg_sl     (vg_sl),
		.vg_sr     (vg_sr),
		.vg_tr43   (vg_tr43),
		.rdat_n    (rdat_n),
		.vg_clk    (vg_clk),
		.vg_res_n  (vg_res_n),
		.vg_hrdy   (vg_hrdy),
		.vg_side   (vg_side),
		.drive_sel (drive_sel),
		.intrq     (intrq),
		.drq       (drq),
		.vg_wrd    (vg_wrd),
		.vg_rclk   (vg_rclk),
		.vg_rawr   (vg_rawr)
	);

	// fibonacci lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task take_bits(input int n, output logic [31:0] v);
		int i;
		begin
			v = 32'd0;
			for (i = 0; i < n; i++)
			begin
				lfsr = lfsr_step(lfsr); // one step per bit
				v    = {v[30:0], lfsr[0]};
			end
		end
	endtask

	// next edge plus 1 ns so outputs settle and inputs may change
	task tick();
		@(posedge fclk);
		#1;
	endtask

	task check_value(input string name, input int expected, input int actual);
		if (expected != actual)
		begin
			$display("FAIL %s expected %0d actual %0d", name, expected, actual);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task set_row(input int idx, input row_kind_e kind, input logic [2:0] stim,
		input int exp_val, input string name);
		row_kind[idx] = kind;
		row_stim[idx] = stim;
		row_exp[idx]  = exp_val;
		row_name[idx] = name;
	endtask

	task fill_table();
		// tr43 moves sl or sr into the inner zone
		set_row(0, k_write, 3'b100, 4, "outer left");
		set_row(1, k_write, 3'b010, 11, "outer right");
		set_row(2, k_write, 3'b101, 0, "inner left");
		set_row(3, k_write, 3'b011, 14, "inner right");
		set_row(4, k_write, 3'b000, 7, "standard");
		for (int i = 5; i < 9; i++)
			set_row(i, k_port, 3'b000, 0, "port ff"); // din comes from the lfsr
		set_row(9, k_rdat, 3'b000, 3, "read");
		set_row(10, k_clk, 3'b000, 28, "vg_clk");
	endtask

	task precomp_delay(input string name, input logic [2:0] shift, input int exp_d);
		int n;
		int w;
		begin
			{vg_sl, vg_sr, vg_tr43} = shift;
			repeat (3) tick(); // levels through the sync flops
			vg_wd = 1'b1;
			tick(); // first sampling edge
			n = 0;
			while (!vg_wrd)
			begin
				tick();
				n++;
				if (n == 3)
					vg_wd = 1'b0; // controller pulse ends
			end
			check_value({name, " delay"}, 4 + exp_d, n);
			w = 1;
			tick();
			while (vg_wrd)
			begin
				w++;
				tick();
			end
			check_value({name, " width"}, 7, w);
			vg_wd = 1'b0;
		end
	endtask

	task port_write(input string name);
		logic [31:0] v;
		begin
			take_bits(8, v);
			din   = v[7:0];
			wr_ff = 1'b1;
			tick(); // register loads here
			wr_ff = 1'b0;
			check_value({name, " side"}, !v[4], vg_side);
			check_value({name, " hrdy"}, v[3], vg_hrdy);
			check_value({name, " res_n"}, v[2], vg_res_n);
			check_value({name, " drive_sel"}, v[1:0], drive_sel);
		end
	endtask

	task read_pulse(input string name, input int exp_delay);
		int n;
		int w;
		int c;
		begin
			rdat_n = 1'b0;
			tick(); // first low sample
			rdat_n = 1'b1;
			n = 0;
			while (!vg_rawr)
			begin
				tick();
				n++;
			end
			check_value({name, " rawr delay"}, exp_delay, n);
			w = 1;
			c = 0;
			while (!vg_rclk) // window opens half a cell later
			begin
				tick();
				c++;
				if (vg_rawr)
					w++;
			end
			check_value({name, " rawr width"}, 4, w);
			check_value({name, " rclk after rawr"}, 56, c);
		end
	endtask

	task wait_clk_rise(output int cycles);
		logic last;
		begin
			cycles = 0;
			last   = vg_clk;
			tick();
			cycles++;
			while (!(vg_clk && !last))
			begin
				last = vg_clk;
				tick();
				cycles++;
			end
		end
	endtask

	task clock_modes(input string name, input int exp_period);
		int p;
		begin
			wait_clk_rise(p); // align to a rise
			wait_clk_rise(p);
			check_value({name, " normal period"}, exp_period, p);
			step = 1'b1;
			repeat (2) tick();
			step = 1'b0;
			wait_clk_rise(p);
			wait_clk_rise(p); // settled from here on
			wait_clk_rise(p);
			check_value({name, " turbo period"}, exp_period / 2, p);
			// drq ends turbo and irq rides along for the status path
			vg_drq = 1'b1;
			vg_irq = 1'b1;
			tick();
			check_value("intrq one edge", 0, intrq);
			check_value("drq one edge", 0, drq);
			tick();
			check_value("intrq rise", 1, intrq);
			check_value("drq rise", 1, drq);
			vg_drq = 1'b0;
			vg_irq = 1'b0;
			tick();
			check_value("intrq hold", 1, intrq);
			check_value("drq hold", 1, drq);
			tick();
			check_value("intrq fall", 0, intrq);
			check_value("drq fall", 0, drq);
			repeat (3) wait_clk_rise(p);
			check_value({name, " period after drq"}, exp_period, p);
		end
	endtask

	// watchdog
	always @(posedge fclk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > cycle_limit)
		begin
			$display("timeout: the tests did not finish within %0d cycles", cycle_limit);
			$display("Something failed");
			$fatal(1);
		end
	end

	initial
	begin
		wr_ff     = 1'b0;
		din       = 8'h00;
		step      = 1'b0;
		vg_drq    = 1'b0;
		vg_irq    = 1'b0;
		vg_wd     = 1'b0;
		vg_sl     = 1'b0;
		vg_sr     = 1'b0;
		vg_tr43   = 1'b0;
		rdat_n    = 1'b1; // idle high
		lfsr      = 32'hac13_7495;
		cycle_cnt = 0;
		fill_table();
		@(posedge rst_n);
		tick();
		check_value("reset vg_res_n", 0, vg_res_n);
		check_value("reset vg_wrd", 0, vg_wrd);
		check_value("reset vg_rawr", 0, vg_rawr);
		check_value("reset vg_side", 0, vg_side);
		check_value("reset vg_hrdy", 0, vg_hrdy);
		check_value("reset drive_sel", 0, drive_sel);
		for (r = 0; r < num_rows; r++)
		begin
			case (row_kind[r])
				k_write: precomp_delay(row_name[r], row_stim[r], row_exp[r]);
				k_port:  port_write(row_name[r]);
				k_rdat:  read_pulse(row_name[r], row_exp[r]);
				default: clock_modes(row_name[r], row_exp[r]);
			endcase
			take_bits(3, gap); // idle gap between rows
			repeat (gap) tick();
		end
		$display("Everything OK");
		$finish;
	end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ns

module tb_clock
(
	output logic fclk,
	output logic rst_n
);

	initial
	begin
		fclk  = 1'b0;
		rst_n = 1'b0;
		repeat (2) @(posedge fclk); // two cycles in reset
		#1 rst_n = 1'b1;
	end

	always #2 fclk = ~fclk; // 4 ns period

endmodule

// File: verilog/fdc_glue.sv
`timescale 1ns/1ns

module fdc_glue
(
	input  logic       fclk,
	input  logic       rst_n,
	input  logic       wr_ff,    // port #FF write
	input  logic [7:0] din,
	input  logic       step,
	input  logic       vg_drq,
	input  logic       vg_irq,
	input  logic       vg_wd,
	input  logic       vg_sl,
	input  logic       vg_sr,
	input  logic       vg_tr43,
	input  logic       rdat_n,
	output logic       vg_clk,
	output logic       vg_res_n,
	output logic       vg_hrdy,
	output logic       vg_side,
	output logic [1:0] drive_sel,
	output logic       intrq,    // to cpu read mux
	output logic       drq,
	output logic       vg_wrd,
	output logic       vg_rclk,
	output logic       vg_rawr
);

	logic step_rise;
	logic drq_rise;
	logic rd_edge;
	logic fire;      // precomp to shaper

	precomp_if pc_if ();

	fdc_sync sync_i
	(
		.fclk      (fclk),
		.rst_n     (rst_n),
		.step      (step),
		.vg_drq    (vg_drq),
		.vg_irq    (vg_irq),
		.vg_wd     (vg_wd),
		.vg_sl     (vg_sl),
		.vg_sr     (vg_sr),
		.vg_tr43   (vg_tr43),
		.rdat_n    (rdat_n),
		.step_rise (step_rise),
		.drq_rise  (drq_rise),
		.intrq     (intrq),
		.drq       (drq),
		.rd_edge   (rd_edge),
		.pc        (pc_if.src)
	);

	// write path, sync then delay then shaper
	wr_precomp precomp_i
	(
		.fclk  (fclk),
		.rst_n (rst_n),
		.pc    (pc_if.dst),
		.fire  (fire)
	);

	wr_pulse pulse_i
	(
		.fclk   (fclk),
		.rst_n  (rst_n),
		.fire   (fire),
		.vg_wrd (vg_wrd)
	);

	vg_clock_gen clk_i
	(
		.fclk      (fclk),
		.rst_n     (rst_n),
		.step_rise (step_rise),
		.drq_rise  (drq_rise),
		.vg_clk    (vg_clk)
	);

	sys_port port_i
	(
		.fclk      (fclk),
		.rst_n     (rst_n),
		.wr_ff     (wr_ff),
		.din       (din),
		.vg_res_n  (vg_res_n),
		.vg_hrdy   (vg_hrdy),
		.vg_side   (vg_side),
		.drive_sel (drive_sel)
	);

	rd_dpll dpll_i
	(
		.fclk    (fclk),
		.rst_n   (rst_n),
		.rd_edge (rd_edge),
		.vg_rclk (vg_rclk),
		.vg_rawr (vg_rawr)
	);

endmodule

// File: verilog/rd_dpll.sv
`timescale 1ns/1ns

module rd_dpll
(
	input  logic fclk,
	input  logic rst_n,
	input  logic rd_edge, // data edge strobe
	output logic vg_rclk, // read window
	output logic vg_rawr  // raw data pulse
);

	import fdc_pkg::*;

	logic [6:0] phase;    // position in bit cell
	logic [2:0] rawr_cnt; // raw pulse cycles left

	// free running cell counter, aligned on every edge
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			phase <= 7'd0;
		else if (rd_edge)
			phase <= 7'd0;
		else if (phase == rclk_period - 7'd1)
			phase <= 7'd0; // no edge, keep running
		else
			phase <= phase + 7'd1;
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			rawr_cnt <= 3'd0;
		else if (rd_edge)
			rawr_cnt <= rawr_width;
		else if (rawr_cnt != 3'd0)
			rawr_cnt <= rawr_cnt - 3'd1;
	end

	// both outputs one flop behind the counters
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			vg_rclk <= 1'b0;
			vg_rawr <= 1'b0;
		end
		else
		begin
			vg_rclk <= (phase >= rclk_half); // low half, then high half
			vg_rawr <= (rawr_cnt != 3'd0);
		end
	end

endmodule

// File: verilog/wr_pulse.sv
`timescale 1ns/1ns

module wr_pulse
(
	input  logic fclk,
	input  logic rst_n,
	input  logic fire,  // from precomp stage
	output logic vg_wrd // fixed width write pulse to drive
);

	import fdc_pkg::*;

	logic [3:0] width_cnt; // cycles left in pulse

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			width_cnt <= 4'd0;
		else if (fire)
			width_cnt <= wrpulse_width; // new edge restarts width
		else if (width_cnt != 4'd0)
			width_cnt <= width_cnt - 4'd1;
	end

	// registered, so no glitch toward the drive
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			vg_wrd <= 1'b0;
		else
			vg_wrd <= (width_cnt != 4'd0);
	end

endmodule

// File: verilog/wr_precomp.sv
`timescale 1ns/1ns

module wr_precomp
(
	input  logic fclk,
	input  logic rst_n,
	precomp_if.dst pc,
	output logic fire // one cycle, delayed write edge
);

	import fdc_pkg::*;

	precomp_e   pc_class;
	logic [3:0] delay;    // delay for current class
	logic [3:0] cnt;
	wrp_state_e state;

	// shift class from the sync levels
	always_comb
	begin
		case ({pc.sl, pc.tr43, pc.sr})
			3'b100:  pc_class = pc_outer_left;
			3'b001:  pc_class = pc_outer_right;
			3'b110:  pc_class = pc_inner_left;
			3'b011:  pc_class = pc_inner_right;
			default: pc_class = pc_standard; // no shift or nonsense combo
		endcase
	end

	always_comb
	begin
		case (pc_class)
			pc_outer_left:  delay = wrdelay_outer_left;
			pc_outer_right: delay = wrdelay_outer_right;
			pc_inner_left:  delay = wrdelay_inner_left;
			pc_inner_right: delay = wrdelay_inner_right;
			default:        delay = wrdelay_standard;
		endcase
	end

	assign fire = (state == wrp_count) && (cnt == 4'd0);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= wrp_idle;
			cnt   <= 4'd0;
		end
		else if (pc.wd_start) // restarts a running count too
		begin
			state <= wrp_count;
			cnt   <= delay;
		end
		else if (state == wrp_count)
		begin
			if (cnt == 4'd0)
				state <= wrp_idle; // fire this cycle
			else
				cnt <= cnt - 4'd1;
		end
	end

endmodule

// File: verilog/sys_port.sv
`timescale 1ns/1ns

module sys_port
(
	input  logic       fclk,
	input  logic       rst_n,
	input  logic       wr_ff,     // port #FF write strobe
	input  logic [7:0] din,       // cpu data
	output logic       vg_res_n,  // controller reset, low after power up
	output logic       vg_hrdy,   // head load to controller HRDY
	output logic       vg_side,
	output logic [1:0] drive_sel  // to the drive decoder
);

	// d6 fm/mfm and d7/d5 not stored
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			vg_res_n  <= 1'b0; // keep controller in reset
			vg_hrdy   <= 1'b0;
			vg_side   <= 1'b0;
			drive_sel <= 2'b00;
		end
		else if (wr_ff)
		begin
			vg_side   <= ~din[4]; // side pin is inverted
			vg_hrdy   <= din[3];
			vg_res_n  <= din[2];
			drive_sel <= din[1:0];
		end
	end

endmodule

// File: verilog/vg_clock_gen.sv
`timescale 1ns/1ns

module vg_clock_gen
(
	input  logic fclk,
	input  logic rst_n,
	input  logic step_rise, // head step started
	input  logic drq_rise,  // data phase reached
	output logic vg_clk
);

	import fdc_pkg::*;

	logic [2:0] div7;    // prescaler phase
	logic       strobe7; // 4 MHz tick
	logic [1:0] div4;    // johnson pair, toggle in turbo
	logic       turbo;

	// drq wins over step
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			turbo <= 1'b0;
		else if (drq_rise)
			turbo <= 1'b0;
		else if (step_rise)
			turbo <= 1'b1;
	end

	assign strobe7 = (div7 == vgclk_prescale - 3'd1);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			div7 <= 3'd0;
		else if (strobe7)
			div7 <= 3'd0;
		else
			div7 <= div7 + 3'd1;
	end

	// 4 ticks per period normally, 2 in turbo
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			div4 <= 2'b00;
		else if (strobe7)
		begin
			div4[0] <= ~div4[1];
			if (turbo)
				div4[1] <= ~div4[1]; // plain toggle, 14 cycles
			else
				div4[1] <= div4[0];  // johnson step, 28 cycles
		end
	end

	assign vg_clk = div4[1];

endmodule

// File: verilog/fdc_sync.sv
`timescale 1ns/1ns

module fdc_sync
(
	input  logic fclk,
	input  logic rst_n,
	input  logic step,     // step from controller
	input  logic vg_drq,
	input  logic vg_irq,
	input  logic vg_wd,    // raw write pulse
	input  logic vg_sl,
	input  logic vg_sr,
	input  logic vg_tr43,
	input  logic rdat_n,   // read data from drive, active low
	output logic step_rise,
	output logic drq_rise,
	output logic intrq,
	output logic drq,
	output logic rd_edge,
	precomp_if.src pc
);

	// three flops where an edge strobe is needed
	logic [2:0] step_s;
	logic [2:0] drq_s;
	logic [2:0] wd_s;
	logic [2:0] rdat_s;
	// two flops for plain levels
	logic [1:0] irq_s;
	logic [1:0] sl_s;
	logic [1:0] sr_s;
	logic [1:0] tr43_s;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			step_s <= 3'b000;
			drq_s  <= 3'b000;
			wd_s   <= 3'b000;
			rdat_s <= 3'b111; // read line idles high
			irq_s  <= 2'b00;
			sl_s   <= 2'b00;
			sr_s   <= 2'b00;
			tr43_s <= 2'b00;
		end
		else
		begin
			step_s <= {step_s[1:0], step};
			drq_s  <= {drq_s[1:0], vg_drq};
			wd_s   <= {wd_s[1:0], vg_wd};
			rdat_s <= {rdat_s[1:0], rdat_n};
			irq_s  <= {irq_s[0], vg_irq};
			sl_s   <= {sl_s[0], vg_sl};
			sr_s   <= {sr_s[0], vg_sr};
			tr43_s <= {tr43_s[0], vg_tr43};
		end
	end

	assign step_rise = step_s[1] & ~step_s[2]; // turbo on
	assign drq_rise  = drq_s[1] & ~drq_s[2];   // turbo off
	assign rd_edge   = ~rdat_s[1] & rdat_s[2]; // falling rdat_n marks a bit

	assign intrq = irq_s[1];
	assign drq   = drq_s[1]; // level taken from the strobe chain

	// precomp side, levels decode to precomp_e downstream
	assign pc.wd_start = wd_s[1] & ~wd_s[2];
	assign pc.sl       = sl_s[1];
	assign pc.sr       = sr_s[1];
	assign pc.tr43     = tr43_s[1];

endmodule

// File: verilog/precomp_if.sv
`timescale 1ns/1ns

// write start plus shift levels, sync stage to precomp stage
interface precomp_if;

	logic wd_start; // one cycle, start of vg_wd
	logic sl;       // shift left request
	logic sr;       // shift right request
	logic tr43;     // inner track zone

	modport src
	(
		output wd_start, sl, sr, tr43
	);

	modport dst
	(
		input wd_start, sl, sr, tr43
	);

endinterface

// File: verilog/fdc_pkg.sv
package fdc_pkg;

	// write precompensation delays in fclk cycles
	localparam logic [3:0] wrdelay_outer_left  = 4'd4;
	localparam logic [3:0] wrdelay_outer_right = 4'd11;
	localparam logic [3:0] wrdelay_inner_left  = 4'd0;  // max shift left, min delay
	localparam logic [3:0] wrdelay_inner_right = 4'd14; // max shift right, max delay
	localparam logic [3:0] wrdelay_standard    = 4'd7;  // no shift, mid point

	localparam logic [3:0] wrpulse_width = 4'd7; // vg_wrd length, cycles

	localparam logic [2:0] vgclk_prescale = 3'd7; // 28 MHz / 7 = 4 MHz strobe

	// read clock regenerator, one bit cell in fclk cycles
	localparam logic [6:0] rclk_period = 7'd112;
	localparam logic [6:0] rclk_half   = 7'd56;  // vg_rclk goes high here
	localparam logic [2:0] rawr_width  = 3'd4;   // raw data pulse length

	// rdat_n low to vg_rawr high, in edges
	localparam int unsigned rawr_delay = 3;

	// shift class from sl/sr/tr43
	typedef enum logic [2:0]
	{
		pc_standard,
		pc_outer_left,
		pc_outer_right,
		pc_inner_left,
		pc_inner_right
	} precomp_e;

	// precomp delay counter state
	typedef enum logic
	{
		wrp_idle,
		wrp_count
	} wrp_state_e;

endpackage
